// ==== hdl/afifo_defs.svh ====
// FIFO sizing shared by every block; depth must be a power of two and thresholds below depth
`ifndef AFIFO_DEFS_SVH
`define AFIFO_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Storage geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define AFIFO_DEPTH 8                             // Entries as a power of two
`define AFIFO_DATA_W 32                           // Payload bits per word

// Index bits plus one wrap bit
`define AFIFO_PTR_W ($clog2(`AFIFO_DEPTH) + 1)

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Flag thresholds where 0 turns the flag off
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define AFIFO_AFULL_TH 2                          // High at depth - TH and above
`define AFIFO_AEMPTY_TH 2                         // High at TH and below

`endif

// ==== hdl/afifo_pkg.sv ====
// Types shared by the FIFO blocks; all widths come from afifo_defs.svh
`include "afifo_defs.svh"

package afifo_pkg;

	// One stored word
	typedef struct packed {
		logic [`AFIFO_DATA_W-1:0] data;
		logic last;                               // Last word of a burst
	} afifo_entry_t;

	// Pointer in both encodings where only the Gray half crosses domains
	typedef struct packed {
		logic [`AFIFO_PTR_W-1:0] bin;
		logic [`AFIFO_PTR_W-1:0] gray;
	} afifo_ptr_t;

	// Write-domain status
	typedef struct packed {
		logic full;
		logic almost_full;
	} afifo_wstat_t;

	// Read-domain status
	typedef struct packed {
		logic empty;
		logic almost_empty;
	} afifo_rstat_t;

endpackage

// ==== hdl/afifo_ptr_sync.sv ====
// Input must be Gray coded and change by one bit per source clock; adds two cycles of latency
`include "afifo_defs.svh"

module afifo_ptr_sync (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic [`AFIFO_PTR_W-1:0] gray_in,
	output logic [`AFIFO_PTR_W-1:0] bin_out
);

	logic [`AFIFO_PTR_W-1:0] gray_meta;           // First stage, may go metastable
	logic [`AFIFO_PTR_W-1:0] gray_sync;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			gray_meta <= '0;
			gray_sync <= '0;
		end else begin
			gray_meta <= gray_in;
			gray_sync <= gray_meta;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Gray to binary where each bit is the XOR of all higher Gray bits
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		for (int i = 0; i < `AFIFO_PTR_W; i++) begin
			bin_out[i] = ^(gray_sync >> i);
		end
	end

endmodule

// ==== hdl/afifo_ram.sv ====
// Write port on w_clk, read port is combinational so read data is ready with the index
`include "afifo_defs.svh"

module afifo_ram
	import afifo_pkg::*;
(
	input  logic                      w_clk,
	input  logic                      wr_en,
	input  logic [`AFIFO_PTR_W-2:0]   wr_idx,
	input  afifo_entry_t              wr_entry,
	input  logic [`AFIFO_PTR_W-2:0]   rd_idx,
	output afifo_entry_t              rd_entry
);

	afifo_entry_t mem [`AFIFO_DEPTH];

	always_ff @(posedge w_clk) begin
		if (wr_en) begin
			mem[wr_idx] <= wr_entry;
		end
	end

	assign rd_entry = mem[rd_idx];                // Fall-through read

endmodule

// ==== hdl/afifo_wr_ctrl.sv ====
// Write side only; sync_rd_bin lags the read side, so full and almost_full are pessimistic
`include "afifo_defs.svh"

module afifo_wr_ctrl
	import afifo_pkg::*;
(
	input  logic                    w_clk,
	input  logic                    r_reset_n,
	input  logic                    in_valid,
	output logic                    in_ready,
	output logic                    wr_en,
	output afifo_ptr_t              wr_ptr,
	input  logic [`AFIFO_PTR_W-1:0] sync_rd_bin,
	output afifo_wstat_t            wstat
);

	localparam logic [`AFIFO_PTR_W-1:0] AFULL_LVL = `AFIFO_DEPTH - `AFIFO_AFULL_TH;

	logic                    rst_meta;
	logic                    w_rst_n;             // Reset released on w_clk
	logic [`AFIFO_PTR_W-1:0] next_bin;
	logic [`AFIFO_PTR_W-1:0] next_gray;
	logic [`AFIFO_PTR_W-1:0] fill_next;
	logic                    full_next;
	logic                    afull_next;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reset release
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge w_clk or negedge r_reset_n) begin
		if (!r_reset_n) begin
			rst_meta <= 1'b0;
			w_rst_n <= 1'b0;
		end else begin
			rst_meta <= 1'b1;
			w_rst_n <= rst_meta;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pointers and flags
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign in_ready = w_rst_n & ~wstat.full;
	assign wr_en = in_valid & in_ready;

	always_comb begin
		next_bin = wr_ptr.bin + {{(`AFIFO_PTR_W-1){1'b0}}, wr_en};
		next_gray = next_bin ^ (next_bin >> 1);
		fill_next = next_bin - sync_rd_bin;       // Words held after this edge
		full_next = (next_bin == {~sync_rd_bin[`AFIFO_PTR_W-1], sync_rd_bin[`AFIFO_PTR_W-2:0]});
		afull_next = (`AFIFO_AFULL_TH != 0) && (fill_next >= AFULL_LVL) && !full_next;
	end

	always_ff @(posedge w_clk or negedge w_rst_n) begin
		if (!w_rst_n) begin
			wr_ptr <= '0;
			wstat.full <= 1'b0;
			wstat.almost_full <= 1'b0;
		end else begin
			wr_ptr.bin <= next_bin;
			wr_ptr.gray <= next_gray;
			wstat.full <= full_next;
			wstat.almost_full <= afull_next;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Assertions
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// No write lands on an entry that is still unread
	a_no_write_when_full: assert property (@(posedge w_clk) disable iff (!w_rst_n)
		fill_next <= `AFIFO_DEPTH);

	// Gray pointer seen by the read domain moves one bit per w_clk
	a_wr_gray_step: assert property (@(posedge w_clk) disable iff (!w_rst_n)
		$countones(wr_ptr.gray ^ $past(wr_ptr.gray)) <= 1);

endmodule

// ==== hdl/afifo_rd_ctrl.sv ====
// Read side only; sync_wr_bin lags the write side, so empty and almost_empty are pessimistic
`include "afifo_defs.svh"

module afifo_rd_ctrl
	import afifo_pkg::*;
(
	input  logic                    r_clk,
	input  logic                    r_reset_n,
	input  logic                    out_ready,
	output logic                    out_valid,
	output afifo_ptr_t              rd_ptr,
	input  logic [`AFIFO_PTR_W-1:0] sync_wr_bin,
	output afifo_rstat_t            rstat
);

	localparam logic [`AFIFO_PTR_W-1:0] AEMPTY_LVL = `AFIFO_AEMPTY_TH;

	logic                    rst_meta;
	logic                    r_rst_n;             // Reset released on r_clk
	logic                    rd_en;
	logic [`AFIFO_PTR_W-1:0] next_bin;
	logic [`AFIFO_PTR_W-1:0] next_gray;
	logic [`AFIFO_PTR_W-1:0] fill_next;
	logic                    empty_next;
	logic                    aempty_next;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reset release
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge r_clk or negedge r_reset_n) begin
		if (!r_reset_n) begin
			rst_meta <= 1'b0;
			r_rst_n <= 1'b0;
		end else begin
			rst_meta <= 1'b1;
			r_rst_n <= rst_meta;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pointers and flags
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign out_valid = ~rstat.empty;
	assign rd_en = out_valid & out_ready;

	always_comb begin
		next_bin = rd_ptr.bin + {{(`AFIFO_PTR_W-1){1'b0}}, rd_en};
		next_gray = next_bin ^ (next_bin >> 1);
		fill_next = sync_wr_bin - next_bin;       // Words left after this edge
		empty_next = (next_bin == sync_wr_bin);
		aempty_next = (`AFIFO_AEMPTY_TH != 0) && (fill_next <= AEMPTY_LVL) && !empty_next;
	end

	always_ff @(posedge r_clk or negedge r_rst_n) begin
		if (!r_rst_n) begin
			rd_ptr <= '0;
			rstat.empty <= 1'b1;                  // Nothing to read out of reset
			rstat.almost_empty <= 1'b0;
		end else begin
			rd_ptr.bin <= next_bin;
			rd_ptr.gray <= next_gray;
			rstat.empty <= empty_next;
			rstat.almost_empty <= aempty_next;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Assertions
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// No read runs past the last synchronized write
	a_no_read_when_empty: assert property (@(posedge r_clk) disable iff (!r_rst_n)
		fill_next <= `AFIFO_DEPTH);

	// Gray pointer seen by the write domain moves one bit per r_clk
	a_rd_gray_step: assert property (@(posedge r_clk) disable iff (!r_rst_n)
		$countones(rd_ptr.gray ^ $past(rd_ptr.gray)) <= 1);

endmodule

// ==== hdl/afifo_top.sv ====
// One external reset for both clocks; in_entry must hold while in_valid waits for in_ready
`include "afifo_defs.svh"

module afifo_top (
	input  logic                   w_clk,
	input  logic                   r_clk,
	input  logic                   r_reset_n,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  afifo_pkg::afifo_entry_t in_entry,
	output logic                   out_valid,
	input  logic                   out_ready,
	output afifo_pkg::afifo_entry_t out_entry,
	output afifo_pkg::afifo_wstat_t wstat,
	output afifo_pkg::afifo_rstat_t rstat
);

	logic                    wr_en;
	afifo_pkg::afifo_ptr_t   wr_ptr;
	afifo_pkg::afifo_ptr_t   rd_ptr;
	logic [`AFIFO_PTR_W-1:0] sync_wr_bin;         // Write pointer on r_clk
	logic [`AFIFO_PTR_W-1:0] sync_rd_bin;         // Read pointer on w_clk

	afifo_wr_ctrl u_wr_ctrl (
		.w_clk       (w_clk),
		.r_reset_n   (r_reset_n),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.wr_en       (wr_en),
		.wr_ptr      (wr_ptr),
		.sync_rd_bin (sync_rd_bin),
		.wstat       (wstat)
	);

	afifo_rd_ctrl u_rd_ctrl (
		.r_clk       (r_clk),
		.r_reset_n   (r_reset_n),
		.out_ready   (out_ready),
		.out_valid   (out_valid),
		.rd_ptr      (rd_ptr),
		.sync_wr_bin (sync_wr_bin),
		.rstat       (rstat)
	);

	afifo_ptr_sync u_wr2rd_sync (
		.clk     (r_clk),
		.reset_n (r_reset_n),
		.gray_in (wr_ptr.gray),
		.bin_out (sync_wr_bin)
	);

	afifo_ptr_sync u_rd2wr_sync (
		.clk     (w_clk),
		.reset_n (r_reset_n),
		.gray_in (rd_ptr.gray),
		.bin_out (sync_rd_bin)
	);

	afifo_ram u_ram (
		.w_clk    (w_clk),
		.wr_en    (wr_en),
		.wr_idx   (wr_ptr.bin[`AFIFO_PTR_W-2:0]),
		.wr_entry (in_entry),
		.rd_idx   (rd_ptr.bin[`AFIFO_PTR_W-2:0]),
		.rd_entry (out_entry)
	);

endmodule

// ==== verif/afifo_tb.sv ====
// Run from the project root; golden flags assume depth 8 and thresholds of 2
module afifo_tb
	import afifo_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	logic         w_clk = 1'b0;
	logic         r_clk = 1'b0;
	logic         r_reset_n = 1'b0;
	logic         in_valid = 1'b0;
	logic         in_ready;
	afifo_entry_t in_entry = '0;
	logic         out_valid;
	logic         out_ready = 1'b0;
	afifo_entry_t out_entry;
	afifo_wstat_t wstat;
	afifo_rstat_t rstat;

	afifo_entry_t wr_q[$];                        // Words still to write
	afifo_entry_t exp_q[$];                       // Words still expected out
	integer       seed = 11;
	int           gaps[64];                       // Handshake gaps shared by both sides
	int           wr_gap = 0;
	int           rd_gap = 0;
	logic         wr_commit = 1'b0;
	logic         rd_on = 1'b0;
	int           accepted = 0;
	int           taken = 0;
	int           fail_count = 0;
	int           rd_fails = 0;
	int           limit = 0;
	string        test_name = "";

	afifo_top afifo_top_i (.*);

	always #4 w_clk = ~w_clk;
	always #6.5 r_clk = ~r_clk;                   // Unrelated to w_clk on purpose

	function automatic int check_val(input string what, input int expv, input int actv);
		int bad;
		bad = 0;
		assert (expv == actv) else begin
			$display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, expv, actv);
			bad = 1;
		end
		return bad;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Producer and consumer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(negedge w_clk) begin
		if (wr_commit) begin                      // Word went in at the last rising edge
			in_valid = 1'b0;
			wr_commit = 1'b0;
			accepted++;
			wr_gap = gaps[accepted % 64];
		end
		if (!in_valid && wr_gap > 0) begin
			wr_gap--;
		end else if (!in_valid && wr_q.size() > 0) begin
			in_entry = wr_q.pop_front();
			in_valid = 1'b1;
		end
		if (in_valid && in_ready) begin
			wr_commit = 1'b1;
		end
	end

	always @(negedge r_clk) begin
		if (rd_gap > 0) begin
			rd_gap--;
			out_ready = 1'b0;
		end else begin
			out_ready = rd_on && exp_q.size() > 0;    // Only take words that are expected
			if (out_ready && out_valid) begin
				rd_fails += check_val("data", exp_q[0].data, out_entry.data);
				rd_fails += check_val("last", int'(exp_q[0].last), int'(out_entry.last));
				void'(exp_q.pop_front());
				taken++;
				rd_gap = gaps[(taken + 29) % 64];
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Command helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Done when queued traffic is through or the writer is held off by full
	task automatic wait_settled();
		int calm;
		calm = 0;
		while (calm < 4) begin
			@(negedge w_clk);
			#1;
			if ((!rd_on || exp_q.size() == 0) && ((wr_q.size() == 0 && !in_valid) || !in_ready))
				calm++;
			else
				calm = 0;
		end
	endtask

	task automatic idle_check(input int cycles, input int full, input int afull,
			input int empty, input int aempty);
		wait_settled();
		repeat (cycles) @(negedge w_clk);
		#1;                                       // Away from both clock edges
		fail_count += check_val("full", full, int'(wstat.full));
		fail_count += check_val("almost_full", afull, int'(wstat.almost_full));
		fail_count += check_val("empty", empty, int'(rstat.empty));
		fail_count += check_val("almost_empty", aempty, int'(rstat.almost_empty));
		fail_count += check_val("in_ready", int'(full == 0), int'(in_ready));
		fail_count += check_val("out_valid", int'(empty == 0), int'(out_valid));
	endtask

	// Every token costs a cycle and idle commands add their length
	function automatic int count_budget(input int fd);
		int    sum;
		int    n;
		int    code;
		string tok;
		string line;
		sum = 0;
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok == "#") begin
				code = $fgets(line, fd);
			end else if (tok == "i") begin
				code = $fscanf(fd, "%d", n);
				sum += n + 1;
			end else begin
				sum++;
			end
		end
		return sum;
	endfunction

	initial begin : watchdog
		int cycles;
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge w_clk);
			cycles++;
		end
		$display("timeout: run stopped after %0d w_clk cycles", cycles);
		$display("Simulation failed");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Golden file replay
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin : main
		int           fd;
		int           code;
		int           n;
		int           f;
		int           af;
		int           e;
		int           ae;
		int           tests_run;
		int           tests_failed;
		int           test_mark;
		int           accept_mark;
		logic [31:0]  d;
		string        op;
		string        line;
		afifo_entry_t ent;
		tests_run = 0;
		tests_failed = 0;
		test_mark = 0;
		accept_mark = 0;
		foreach (gaps[k]) gaps[k] = $random(seed) & 3;
		fd = $fopen("verif/afifo_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open verif/afifo_golden.txt");
			$display("Simulation failed");
			$finish;
		end else begin
			limit = 4 * count_budget(fd) + 200;
			$fclose(fd);
			fd = $fopen("verif/afifo_golden.txt", "r");
			repeat (10) @(negedge w_clk);
			r_reset_n = 1'b1;
			while ($fscanf(fd, "%s", op) == 1) begin
				case (op)
					"#": code = $fgets(line, fd);
					"test": begin
						code = $fscanf(fd, "%s", op);
						wait_settled();
						if (test_name != "") begin
							tests_run++;
							tests_failed += (fail_count + rd_fails != test_mark) ? 1 : 0;
							$display("test %s: %0d errors", test_name,
								fail_count + rd_fails - test_mark);
						end
						test_name = op;
						test_mark = fail_count + rd_fails;
						accept_mark = accepted;
					end
					"w", "r": begin
						code = $fscanf(fd, "%h %d", d, n);
						ent.data = d;
						ent.last = n[0];
						if (op == "w")
							wr_q.push_back(ent);
						else
							exp_q.push_back(ent);
					end
					"rdy": begin
						code = $fscanf(fd, "%d", n);
						rd_on = n[0];
					end
					"n": begin
						code = $fscanf(fd, "%d", n);
						wait_settled();
						fail_count += check_val("writes accepted", n, accepted - accept_mark);
					end
					"i": begin
						code = $fscanf(fd, "%d %d %d %d %d", n, f, af, e, ae);
						idle_check(n, f, af, e, ae);
					end
					default: begin
						$display("unknown command %s in the golden file", op);
						fail_count++;
					end
				endcase
			end
			$fclose(fd);
			wait_settled();
			tests_run++;
			tests_failed += (fail_count + rd_fails != test_mark) ? 1 : 0;
			$display("test %s: %0d errors", test_name, fail_count + rd_fails - test_mark);
			assert (wr_q.size() == 0 && exp_q.size() == 0) else begin
				$display("words were left unsent or unread at the end of the golden file");
				fail_count++;
			end
			$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
				fail_count + rd_fails);
			if (fail_count + rd_fails == 0)
				$display("Simulation passed");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

// ==== verif/afifo_golden.txt ====
# Tokens: test <name> opens a record; w <hex> <last> writes; r <hex> <last> expects a read
# rdy <0|1> stalls or frees reads; n <k> writes accepted; i <cyc> <full> <afull> <empty> <aempty>
test reset_state
i 4 0 0 1 0
test burst_order
rdy 1
w deadbeef 0 w 00000001 0 w 12345678 0 w ffffffff 1 w 0 0 w 80000000 1
w a5a5a5a5 0 w 5a5a5a5a 0 w 13 1 w 14 0 w 15 0 w 16 1
w cafef00d 0 w 7fffffff 1 w 19 0 w 1a 1
r deadbeef 0 r 00000001 0 r 12345678 0 r ffffffff 1 r 0 0 r 80000000 1
r a5a5a5a5 0 r 5a5a5a5a 0 r 13 1 r 14 0 r 15 0 r 16 1
r cafef00d 0 r 7fffffff 1 r 19 0 r 1a 1
i 8 0 0 1 0 n 16
test full_stall
rdy 0
w b01 0 w b02 0 w b03 0 w b04 1 w b05 0 w b06 0 w b07 0 w b08 1 w b09 1
i 8 1 0 0 0 n 8
r b01 0 r b02 0 r b03 0 r b04 1 r b05 0 r b06 0 r b07 0 r b08 1 r b09 1
rdy 1 i 8 0 0 1 0 n 9
test afull_levels
rdy 0 w c01 0 w c02 0 w c03 0 w c04 0 w c05 0 i 8 0 0 0 0
w c06 0 i 8 0 1 0 0
w c07 0 i 8 0 1 0 0
w c08 1 i 8 1 0 0 0
test aempty_levels
rdy 1 r c01 0 r c02 0 r c03 0 r c04 0 r c05 0 i 8 0 0 0 0
r c06 0 i 8 0 0 0 1
r c07 0 i 8 0 0 0 1
r c08 1 i 8 0 0 1 0
test wrap_refill
rdy 0 w d01 0 w d02 0 w d03 0 w d04 1 w d05 0 w d06 0 w d07 0 w d08 1
i 8 1 0 0 0
w d09 0 w d0a 0 w d0b 0 w d0c 1 w d0d 0 w d0e 0 w d0f 0 w d10 1
r d01 0 r d02 0 r d03 0 r d04 1 r d05 0 r d06 0 r d07 0 r d08 1
r d09 0 r d0a 0 r d0b 0 r d0c 1 r d0d 0 r d0e 0 r d0f 0 r d10 1
rdy 1 i 8 0 0 1 0 n 16

// ==== tb.f ====
+incdir+hdl
hdl/afifo_pkg.sv
hdl/afifo_ptr_sync.sv
hdl/afifo_ram.sv
hdl/afifo_wr_ctrl.sv
hdl/afifo_rd_ctrl.sv
hdl/afifo_top.sv
verif/afifo_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := afifo_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) hdl/afifo_defs.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN) verif/afifo_golden.txt
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
